/* dv/npc_soc_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_soc_tb
  import soc_pkg::*;
();

  localparam int MEM_WORDS    = 1024;
  localparam int PERIOD       = 4;
  localparam int RESET_CYCLES = 5;
  localparam int PASSES       = 2;
  localparam int ROW_TIME_NS  = 200;
  localparam int NO_CHAR      = -1;
  localparam logic [31:0] SEED       = 32'h3fe75503;
  localparam logic [31:0] WINDOW_END = MEM_BASE + 32'(MEM_WORDS * 4);
  localparam logic [31:0] TOP_WORD   = WINDOW_END - 32'd4;

  logic         clock = 1'b0;
  logic         reset;
  logic         req_valid;
  logic         req_ready;
  lsu_op_e      req_op;
  access_size_e req_size;
  logic [31:0]  req_addr;
  logic [31:0]  req_wdata;
  logic         rsp_valid;
  logic         rsp_ready = 1'b1;
  logic [31:0]  rsp_rdata;
  logic         rsp_error;
  logic         serial_valid;
  logic [7:0]   serial_data;

  // stimulus table, one entry per request
  string        row_name[$];
  lsu_op_e      row_op[$];
  access_size_e row_size[$];
  logic [31:0]  row_addr[$];
  logic [31:0]  row_wdata[$];
  logic [31:0]  row_rdata[$];
  logic         row_error[$];
  int           row_char[$];

  logic         table_ready = 1'b0;
  logic         random_ready = 1'b0;
  int           rsp_count = 0;
  logic [7:0]   serial_seen[$];

  npc_soc #(
    .MEM_WORDS(MEM_WORDS)
  ) u_npc_soc (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_op      (req_op),
    .req_size    (req_size),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_rdata   (rsp_rdata),
    .rsp_error   (rsp_error),
    .serial_valid(serial_valid),
    .serial_data (serial_data)
  );

  always #(PERIOD / 2) clock = ~clock;

  // back-pressure on the response port
  always @(posedge clock) begin
    if (random_ready) begin
      rsp_ready <= ($urandom & 32'h1) != 32'h0;
    end else begin
      rsp_ready <= 1'b1;
    end
  end

  always @(posedge clock) begin
    if (!reset && rsp_valid && rsp_ready) begin
      rsp_count <= rsp_count + 1;
    end
  end

  always @(posedge clock) begin
    if (!reset && serial_valid) begin
      serial_seen.push_back(serial_data);
    end
  end

  task automatic check(input string test, input string field,
                       input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: %s expected %h actual %h", test, field, expected, actual);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  task automatic add_row(input string name, input lsu_op_e op, input access_size_e size,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [31:0] rdata, input logic error, input int chr);
    row_name.push_back(name);
    row_op.push_back(op);
    row_size.push_back(size);
    row_addr.push_back(addr);
    row_wdata.push_back(wdata);
    row_rdata.push_back(rdata);
    row_error.push_back(error);
    row_char.push_back(chr);
  endtask

  task automatic build_table();
    // whole words, top of the window too
    add_row("st_word0", STORE, WORD, MEM_BASE, 32'h1122_3344, 32'h0, 1'b0, NO_CHAR);
    add_row("st_word4", STORE, WORD, MEM_BASE + 32'h10, 32'hdead_beef, 32'h0, 1'b0, NO_CHAR);
    add_row("st_alias", STORE, WORD, MEM_BASE + 32'h3f8, 32'h5a5a_0001, 32'h0, 1'b0, NO_CHAR);
    add_row("st_top", STORE, WORD, TOP_WORD, 32'hcafe_f00d, 32'h0, 1'b0, NO_CHAR);
    add_row("ld_word0", LOAD, WORD, MEM_BASE, 32'h0, 32'h1122_3344, 1'b0, NO_CHAR);
    add_row("ld_word4", LOAD, WORD, MEM_BASE + 32'h10, 32'h0, 32'hdead_beef, 1'b0, NO_CHAR);
    add_row("ld_top", LOAD, WORD, TOP_WORD, 32'h0, 32'hcafe_f00d, 1'b0, NO_CHAR);
    // partial stores merge into their lanes
    add_row("st_byte2", STORE, BYTE, MEM_BASE + 32'h2, 32'h0000_00a5, 32'h0, 1'b0, NO_CHAR);
    add_row("st_half_hi", STORE, HALF, MEM_BASE + 32'h12, 32'h0000_1234, 32'h0, 1'b0, NO_CHAR);
    add_row("st_half_top", STORE, HALF, TOP_WORD, 32'h0000_7788, 32'h0, 1'b0, NO_CHAR);
    add_row("ld_merge0", LOAD, WORD, MEM_BASE, 32'h0, 32'h11a5_3344, 1'b0, NO_CHAR);
    add_row("ld_merge4", LOAD, WORD, MEM_BASE + 32'h10, 32'h0, 32'h1234_beef, 1'b0, NO_CHAR);
    add_row("ld_merge_top", LOAD, WORD, TOP_WORD, 32'h0, 32'hcafe_7788, 1'b0, NO_CHAR);
    add_row("ld_byte1", LOAD, BYTE, MEM_BASE + 32'h1, 32'h0, 32'h0000_0033, 1'b0, NO_CHAR);
    add_row("ld_byte2", LOAD, BYTE, MEM_BASE + 32'h2, 32'h0, 32'h0000_00a5, 1'b0, NO_CHAR);
    add_row("ld_byte3", LOAD, BYTE, MEM_BASE + 32'h3, 32'h0, 32'h0000_0011, 1'b0, NO_CHAR);
    add_row("ld_half_lo", LOAD, HALF, MEM_BASE, 32'h0, 32'h0000_3344, 1'b0, NO_CHAR);
    add_row("ld_half_hi", LOAD, HALF, MEM_BASE + 32'h12, 32'h0, 32'h0000_1234, 1'b0, NO_CHAR);
    // misaligned, no bus access
    add_row("st_half_mis", STORE, HALF, MEM_BASE + 32'h1, 32'hffff_ffff, 32'h0, 1'b1, NO_CHAR);
    add_row("st_word_mis", STORE, WORD, MEM_BASE + 32'h12, 32'hffff_ffff, 32'h0, 1'b1, NO_CHAR);
    add_row("ld_word_mis", LOAD, WORD, MEM_BASE + 32'h2, 32'h0, 32'h0, 1'b1, NO_CHAR);
    add_row("ld_half_mis", LOAD, HALF, TOP_WORD + 32'h3, 32'h0, 32'h0, 1'b1, NO_CHAR);
    add_row("ld_after_mis0", LOAD, WORD, MEM_BASE, 32'h0, 32'h11a5_3344, 1'b0, NO_CHAR);
    add_row("ld_after_mis4", LOAD, WORD, MEM_BASE + 32'h10, 32'h0, 32'h1234_beef, 1'b0, NO_CHAR);
    // unmapped addresses
    add_row("ld_low", LOAD, WORD, 32'h0000_1000, 32'h0, 32'h0, 1'b1, NO_CHAR);
    add_row("ld_below", LOAD, WORD, MEM_BASE - 32'h4, 32'h0, 32'h0, 1'b1, NO_CHAR);
    add_row("st_past_top", STORE, WORD, WINDOW_END, 32'h0bad_0bad, 32'h0, 1'b1, NO_CHAR);
    add_row("ld_past_top", LOAD, WORD, WINDOW_END, 32'h0, 32'h0, 1'b1, NO_CHAR);
    add_row("st_near_ser", STORE, WORD, SERIAL_ADDR + 32'h4, 32'h41, 32'h0, 1'b1, NO_CHAR);
    // serial port, low byte is the character
    add_row("ser_word", STORE, WORD, SERIAL_ADDR, 32'h1234_5648, 32'h0, 1'b0, 32'h48);
    add_row("ser_byte", STORE, BYTE, SERIAL_ADDR, 32'h0000_0069, 32'h0, 1'b0, 32'h69);
    add_row("ser_half", STORE, HALF, SERIAL_ADDR, 32'h0000_ff0a, 32'h0, 1'b0, 32'h0a);
    add_row("ld_serial", LOAD, WORD, SERIAL_ADDR, 32'h0, 32'h0, 1'b0, NO_CHAR);
    add_row("ld_alias", LOAD, WORD, MEM_BASE + 32'h3f8, 32'h0, 32'h5a5a_0001, 1'b0, NO_CHAR);
    add_row("ld_after_ser0", LOAD, WORD, MEM_BASE, 32'h0, 32'h11a5_3344, 1'b0, NO_CHAR);
  endtask

  task automatic run_row(input int i, input int done);
    logic [7:0] chr;
    @(posedge clock);
    check(row_name[i], "response count", done, rsp_count);
    req_valid <= 1'b1;
    req_op    <= row_op[i];
    req_size  <= row_size[i];
    req_addr  <= row_addr[i];
    req_wdata <= row_wdata[i];
    do begin
      @(posedge clock);
    end while (!req_ready);
    req_valid <= 1'b0;
    // no new request taken while this one is outstanding
    do begin
      @(posedge clock);
      check(row_name[i], "req_ready", 32'd0, 32'(req_ready));
    end while (!(rsp_valid && rsp_ready));
    check(row_name[i], "rdata", row_rdata[i], rsp_rdata);
    check(row_name[i], "error", 32'(row_error[i]), 32'(rsp_error));
    // character shows up before the store response
    if (row_char[i] == NO_CHAR) begin
      check(row_name[i], "serial count", 32'd0, serial_seen.size());
    end else begin
      check(row_name[i], "serial count", 32'd1, serial_seen.size());
      chr = serial_seen.pop_front();
      check(row_name[i], "serial char", row_char[i], 32'(chr));
    end
  endtask

  initial begin
    int done;
    void'($urandom(SEED));
    reset     = 1'b1;
    req_valid = 1'b0;
    req_op    = LOAD;
    req_size  = WORD;
    req_addr  = '0;
    req_wdata = '0;
    build_table();
    table_ready = 1'b1;
    done = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    // second pass repeats the table under back-pressure
    for (int pass = 0; pass < PASSES; pass++) begin
      random_ready <= (pass == 1);
      for (int i = 0; i < row_name.size(); i++) begin
        run_row(i, done);
        done++;
      end
    end
    repeat (2) @(posedge clock);
    check("end", "response count", done, rsp_count);
    check("end", "serial chars left", 32'd0, serial_seen.size());
    $display("No errors");
    $finish;
  end

  initial begin
    int timeout_ns;
    wait (table_ready);
    timeout_ns = RESET_CYCLES * PERIOD + PASSES * row_name.size() * ROW_TIME_NS;
    #(timeout_ns);
    $display("Errors found");
    $fatal(1, "timeout: no response from DUT");
  end

endmodule

`default_nettype wire

/* hw/axi_addr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_addr_decoder
  import soc_pkg::*;
#(
  parameter int MEM_WORDS = 1024
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic [STRB_WIDTH-1:0] wstrb,
  input  logic                  wlast,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rlast,
  output logic                  mem_awvalid,
  input  logic                  mem_awready,
  output logic [ADDR_WIDTH-1:0] mem_awaddr,
  output logic                  mem_wvalid,
  input  logic                  mem_wready,
  output logic [DATA_WIDTH-1:0] mem_wdata,
  output logic [STRB_WIDTH-1:0] mem_wstrb,
  output logic                  mem_wlast,
  input  logic                  mem_bvalid,
  output logic                  mem_bready,
  input  logic [1:0]            mem_bresp,
  output logic                  mem_arvalid,
  input  logic                  mem_arready,
  output logic [ADDR_WIDTH-1:0] mem_araddr,
  input  logic                  mem_rvalid,
  output logic                  mem_rready,
  input  logic [DATA_WIDTH-1:0] mem_rdata,
  input  logic [1:0]            mem_rresp,
  input  logic                  mem_rlast,
  output logic                  ser_awvalid,
  input  logic                  ser_awready,
  output logic                  ser_wvalid,
  input  logic                  ser_wready,
  output logic [DATA_WIDTH-1:0] ser_wdata,
  output logic [STRB_WIDTH-1:0] ser_wstrb,
  output logic                  ser_wlast,
  input  logic                  ser_bvalid,
  output logic                  ser_bready,
  input  logic [1:0]            ser_bresp,
  output logic                  ser_arvalid,
  input  logic                  ser_arready,
  input  logic                  ser_rvalid,
  output logic                  ser_rready,
  input  logic [DATA_WIDTH-1:0] ser_rdata,
  input  logic [1:0]            ser_rresp,
  input  logic                  ser_rlast
);

  localparam logic [ADDR_WIDTH-1:0] MEM_BYTES = ADDR_WIDTH'(MEM_WORDS * 4);

  // target select, bit 0 memory, bit 1 serial, bit 2 unmapped
  logic [2:0]            w_sel;
  logic [2:0]            r_sel;
  logic [2:0]            aw_dec;
  logic [2:0]            ar_dec;
  logic                  w_taken;
  logic                  aw_fwd;
  logic                  w_fwd;
  logic                  ar_fwd;
  logic                  dec_bvalid;
  logic                  dec_rvalid;
  logic [ADDR_WIDTH-1:0] awaddr_q;
  logic [ADDR_WIDTH-1:0] araddr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  logic                  wlast_q;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic                  ar_hs;
  logic                  r_hs;

  function automatic logic [2:0] decode(input logic [ADDR_WIDTH-1:0] addr);
    logic in_mem;
    logic in_ser;
    in_mem = (addr - MEM_BASE) < MEM_BYTES;
    in_ser = (addr == SERIAL_ADDR);
    return {!in_mem && !in_ser, in_ser, in_mem};
  endfunction

  assign aw_dec = decode(awaddr);
  assign ar_dec = decode(araddr);
  assign aw_hs  = awvalid && awready;
  assign w_hs   = wvalid && wready;
  assign b_hs   = bvalid && bready;
  assign ar_hs  = arvalid && arready;
  assign r_hs   = rvalid && rready;

  assign awready = (w_sel == 3'b000);
  assign wready  = !w_taken;
  assign arready = (r_sel == 3'b000);

  assign mem_awvalid = aw_fwd && w_sel[0];
  assign mem_wvalid  = w_fwd && w_sel[0];
  assign mem_arvalid = ar_fwd && r_sel[0];
  assign ser_awvalid = aw_fwd && w_sel[1];
  assign ser_wvalid  = w_fwd && w_sel[1];
  assign ser_arvalid = ar_fwd && r_sel[1];
  assign mem_awaddr  = awaddr_q;
  assign mem_araddr  = araddr_q;
  assign mem_wdata   = wdata_q;
  assign ser_wdata   = wdata_q;
  assign mem_wstrb   = wstrb_q;
  assign ser_wstrb   = wstrb_q;
  assign mem_wlast   = wlast_q;
  assign ser_wlast   = wlast_q;
  assign mem_bready  = bready && w_sel[0];
  assign ser_bready  = bready && w_sel[1];
  assign mem_rready  = rready && r_sel[0];
  assign ser_rready  = rready && r_sel[1];

  // responses come straight back from the selected target
  always_comb begin
    case (w_sel)
      3'b001: {bvalid, bresp} = {mem_bvalid, mem_bresp};
      3'b010: {bvalid, bresp} = {ser_bvalid, ser_bresp};
      default: {bvalid, bresp} = {dec_bvalid, DECERR};
    endcase
    case (r_sel)
      3'b001: {rvalid, rdata, rresp, rlast} = {mem_rvalid, mem_rdata, mem_rresp, mem_rlast};
      3'b010: {rvalid, rdata, rresp, rlast} = {ser_rvalid, ser_rdata, ser_rresp, ser_rlast};
      default: {rvalid, rdata, rresp, rlast} = {dec_rvalid, 32'h0, DECERR, 1'b1};
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || b_hs) begin
      w_sel      <= '0;
      w_taken    <= 1'b0;
      aw_fwd     <= 1'b0;
      w_fwd      <= 1'b0;
      dec_bvalid <= 1'b0;
    end else begin
      if (aw_hs) begin
        w_sel  <= aw_dec;
        aw_fwd <= 1'b1;
      end else if ((mem_awvalid && mem_awready) || (ser_awvalid && ser_awready)) begin
        aw_fwd <= 1'b0;
      end
      if (w_hs) begin
        w_taken <= 1'b1;
        w_fwd   <= 1'b1;
      end else if ((mem_wvalid && mem_wready) || (ser_wvalid && ser_wready)) begin
        w_fwd <= 1'b0;
      end
      // unmapped write answered once address and data are both in
      if (((aw_hs && aw_dec[2]) || w_sel[2]) && (w_hs || w_taken)) begin
        dec_bvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || r_hs) begin
      r_sel      <= '0;
      ar_fwd     <= 1'b0;
      dec_rvalid <= 1'b0;
    end else if (ar_hs) begin
      r_sel      <= ar_dec;
      ar_fwd     <= 1'b1;
      dec_rvalid <= ar_dec[2];
    end else if ((mem_arvalid && mem_arready) || (ser_arvalid && ser_arready)) begin
      ar_fwd <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (aw_hs) begin
      awaddr_q <= awaddr;
    end
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
      wlast_q <= wlast;
    end
    if (ar_hs) begin
      araddr_q <= araddr;
    end
  end

  // a write goes to exactly one place
  assert property (@(posedge clock) disable iff (reset) $onehot0(w_sel));

endmodule

`default_nettype wire

/* hw/axi_mem_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_mem_slave
  import soc_pkg::*;
#(
  parameter int MEM_WORDS = 1024
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic [STRB_WIDTH-1:0] wstrb,
  input  logic                  wlast,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rlast
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  typedef enum logic [1:0] {
    WIDLE,
    WDATA,
    WRESP
  } mem_wstate_e;

  typedef enum logic {
    RIDLE,
    RVALID
  } mem_rstate_e;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  mem_wstate_e           wstate;
  mem_rstate_e           rstate;
  logic                  aw_got;
  logic                  w_got;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  aw_ok;
  logic                  w_ok;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;
  logic [DATA_WIDTH-1:0] rdata_q;

  assign awready = (wstate == WIDLE) || (wstate == WDATA && !aw_got);
  assign wready  = (wstate == WIDLE) || (wstate == WDATA && !w_got);
  assign bvalid  = (wstate == WRESP);
  assign bresp   = OKAY;

  assign arready = (rstate == RIDLE);
  assign rvalid  = (rstate == RVALID);
  assign rdata   = rdata_q;
  assign rresp   = OKAY;
  assign rlast   = 1'b1;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign aw_ok = aw_got || aw_hs;
  assign w_ok  = w_got || (w_hs && wlast);

  // whichever channel came first is taken from its latch
  assign wr_addr = aw_hs ? awaddr : addr_q;
  assign wr_data = w_hs ? wdata : wdata_q;
  assign wr_strb = w_hs ? wstrb : wstrb_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wstate <= WIDLE;
      rstate <= RIDLE;
      aw_got <= 1'b0;
      w_got  <= 1'b0;
    end else begin
      case (wstate)
        WIDLE, WDATA: begin
          aw_got <= aw_ok;
          w_got  <= w_ok;
          if (aw_ok && w_ok) begin
            wstate <= WRESP;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
          end else if (aw_hs || w_hs) begin
            wstate <= WDATA;
          end
        end
        WRESP: begin
          if (bready) begin
            wstate <= WIDLE;
          end
        end
        default: wstate <= WIDLE;
      endcase

      case (rstate)
        RIDLE: begin
          if (arvalid) begin
            rstate <= RVALID;
          end
        end
        RVALID: begin
          if (rready) begin
            rstate <= RIDLE;
          end
        end
        default: rstate <= RIDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (aw_hs) begin
      addr_q <= awaddr;
    end
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (aw_ok && w_ok) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wr_strb[i]) begin
          mem[wr_addr[IDX_W+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
    if (arvalid && arready) begin
      rdata_q <= mem[araddr[IDX_W+1:2]];
    end
  end

  // write response held until the master takes it
  assert property (@(posedge clock) disable iff (reset) bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

/* hw/axi_serial_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_serial_slave
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic [STRB_WIDTH-1:0] wstrb,
  input  logic                  wlast,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rlast,
  output logic                  serial_valid,
  output logic [7:0]            serial_data
);

  logic aw_got;
  logic w_got;
  logic aw_hs;
  logic w_hs;
  logic aw_ok;
  logic w_ok;
  logic char_q;

  assign awready = !bvalid && !aw_got;
  assign wready  = !bvalid && !w_got;
  assign bresp   = OKAY;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign aw_ok   = aw_got || aw_hs;
  assign w_ok    = w_got || (w_hs && wlast);

  // nothing to read back
  assign arready = !rvalid;
  assign rdata   = '0;
  assign rresp   = OKAY;
  assign rlast   = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_got       <= 1'b0;
      w_got        <= 1'b0;
      bvalid       <= 1'b0;
      rvalid       <= 1'b0;
      serial_valid <= 1'b0;
    end else begin
      serial_valid <= 1'b0;
      if (bvalid) begin
        if (bready) begin
          bvalid <= 1'b0;
        end
      end else if (aw_ok && w_ok) begin
        bvalid       <= 1'b1;
        aw_got       <= 1'b0;
        w_got        <= 1'b0;
        // character goes out with the write response
        serial_valid <= w_hs ? wstrb[0] : char_q;
      end else begin
        aw_got <= aw_ok;
        w_got  <= w_ok;
      end
      if (arvalid && arready) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (w_hs) begin
      char_q      <= wstrb[0];
      serial_data <= wdata[7:0];
    end
  end

endmodule

`default_nettype wire

/* hw/lsu_axi_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_axi_bridge
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  lsu_op_e               req_op,
  input  access_size_e          req_size,
  input  logic [ADDR_WIDTH-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0] req_wdata,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic [DATA_WIDTH-1:0] rsp_rdata,
  output logic                  rsp_error,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [ADDR_WIDTH-1:0] awaddr,
  output logic                  wvalid,
  input  logic                  wready,
  output logic [DATA_WIDTH-1:0] wdata,
  output logic [STRB_WIDTH-1:0] wstrb,
  output logic                  wlast,
  input  logic                  bvalid,
  output logic                  bready,
  input  logic [1:0]            bresp,
  output logic                  arvalid,
  input  logic                  arready,
  output logic [ADDR_WIDTH-1:0] araddr,
  input  logic                  rvalid,
  output logic                  rready,
  input  logic [DATA_WIDTH-1:0] rdata,
  input  logic [1:0]            rresp,
  input  logic                  rlast
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    WAIT,
    RESP
  } bridge_state_e;

  bridge_state_e         state;
  lsu_op_e               op_q;
  access_size_e          size_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] strb_q;
  logic                  aw_done;
  logic                  w_done;
  logic                  aw_ok;
  logic                  w_ok;
  logic                  aligned;
  logic [STRB_WIDTH-1:0] strb;
  logic [DATA_WIDTH-1:0] lane_data;
  logic [DATA_WIDTH-1:0] load_data;

  // alignment and byte lanes of the incoming request
  always_comb begin
    aligned = 1'b0;
    strb    = '0;
    case (req_size)
      BYTE: begin
        aligned = 1'b1;
        strb    = 4'b0001 << req_addr[1:0];
      end
      HALF: begin
        aligned = ~req_addr[0];
        strb    = 4'b0011 << req_addr[1:0];
      end
      WORD: begin
        aligned = (req_addr[1:0] == 2'b00);
        strb    = 4'b1111;
      end
      default: strb = '0;
    endcase
  end

  // addressed lane moved down, zero-extended
  assign lane_data = rdata >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (size_q)
      BYTE:    load_data = {24'h0, lane_data[7:0]};
      HALF:    load_data = {16'h0, lane_data[15:0]};
      default: load_data = rdata;
    endcase
  end

  assign req_ready = (state == IDLE);
  assign rsp_valid = (state == RESP);

  assign awvalid = (state == ADDR) && (op_q == STORE) && !aw_done;
  assign wvalid  = (state == ADDR) && (op_q == STORE) && !w_done;
  assign arvalid = (state == ADDR) && (op_q == LOAD);
  assign awaddr  = addr_q;
  assign araddr  = addr_q;
  assign wdata   = wdata_q;
  assign wstrb   = strb_q;
  assign wlast   = 1'b1;
  assign bready  = 1'b1;
  assign rready  = 1'b1;

  assign aw_ok = aw_done || (awvalid && awready);
  assign w_ok  = w_done || (wvalid && wready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          if (req_valid) begin
            state <= aligned ? ADDR : RESP;
          end
        end
        ADDR: begin
          aw_done <= aw_ok;
          w_done  <= w_ok;
          if ((op_q == STORE) ? (aw_ok && w_ok) : arready) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if ((op_q == STORE) ? bvalid : (rvalid && rlast)) begin
            state <= RESP;
          end
        end
        RESP: begin
          if (rsp_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      op_q      <= req_op;
      size_q    <= req_size;
      addr_q    <= req_addr;
      wdata_q   <= req_wdata << {req_addr[1:0], 3'b000};
      strb_q    <= strb;
      // misaligned requests end here
      rsp_rdata <= '0;
      rsp_error <= !aligned;
    end else if (state == WAIT && op_q == STORE && bvalid) begin
      rsp_rdata <= '0;
      rsp_error <= (bresp != OKAY);
    end else if (state == WAIT && op_q == LOAD && rvalid && rlast) begin
      rsp_rdata <= (rresp == OKAY) ? load_data : '0;
      rsp_error <= (rresp != OKAY);
    end
  end

  // response held unchanged until the port takes it
  assert property (@(posedge clock) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_error));

endmodule

`default_nettype wire

/* hw/npc_soc.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_soc
  import soc_pkg::*;
#(
  parameter int MEM_WORDS = 1024
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  lsu_op_e               req_op,
  input  access_size_e          req_size,
  input  logic [ADDR_WIDTH-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0] req_wdata,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic [DATA_WIDTH-1:0] rsp_rdata,
  output logic                  rsp_error,
  output logic                  serial_valid,
  output logic [7:0]            serial_data
);

  // bridge to decoder
  logic                  awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready, rlast;
  logic [ADDR_WIDTH-1:0] awaddr, araddr;
  logic [DATA_WIDTH-1:0] wdata, rdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic [1:0]            bresp, rresp;

  // decoder to memory
  logic                  mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_wlast;
  logic                  mem_bvalid, mem_bready, mem_arvalid, mem_arready;
  logic                  mem_rvalid, mem_rready, mem_rlast;
  logic [ADDR_WIDTH-1:0] mem_awaddr, mem_araddr;
  logic [DATA_WIDTH-1:0] mem_wdata, mem_rdata;
  logic [STRB_WIDTH-1:0] mem_wstrb;
  logic [1:0]            mem_bresp, mem_rresp;

  // decoder to serial port
  logic                  ser_awvalid, ser_awready, ser_wvalid, ser_wready, ser_wlast;
  logic                  ser_bvalid, ser_bready, ser_arvalid, ser_arready;
  logic                  ser_rvalid, ser_rready, ser_rlast;
  logic [DATA_WIDTH-1:0] ser_wdata, ser_rdata;
  logic [STRB_WIDTH-1:0] ser_wstrb;
  logic [1:0]            ser_bresp, ser_rresp;

  lsu_axi_bridge u_bridge (.*);

  axi_addr_decoder #(
    .MEM_WORDS(MEM_WORDS)
  ) u_decoder (.*);

  axi_mem_slave #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem (
    .clock  (clock),
    .reset  (reset),
    .awvalid(mem_awvalid),
    .awready(mem_awready),
    .awaddr (mem_awaddr),
    .wvalid (mem_wvalid),
    .wready (mem_wready),
    .wdata  (mem_wdata),
    .wstrb  (mem_wstrb),
    .wlast  (mem_wlast),
    .bvalid (mem_bvalid),
    .bready (mem_bready),
    .bresp  (mem_bresp),
    .arvalid(mem_arvalid),
    .arready(mem_arready),
    .araddr (mem_araddr),
    .rvalid (mem_rvalid),
    .rready (mem_rready),
    .rdata  (mem_rdata),
    .rresp  (mem_rresp),
    .rlast  (mem_rlast)
  );

  axi_serial_slave u_serial (
    .clock       (clock),
    .reset       (reset),
    .awvalid     (ser_awvalid),
    .awready     (ser_awready),
    .wvalid      (ser_wvalid),
    .wready      (ser_wready),
    .wdata       (ser_wdata),
    .wstrb       (ser_wstrb),
    .wlast       (ser_wlast),
    .bvalid      (ser_bvalid),
    .bready      (ser_bready),
    .bresp       (ser_bresp),
    .arvalid     (ser_arvalid),
    .arready     (ser_arready),
    .rvalid      (ser_rvalid),
    .rready      (ser_rready),
    .rdata       (ser_rdata),
    .rresp       (ser_rresp),
    .rlast       (ser_rlast),
    .serial_valid(serial_valid),
    .serial_data (serial_data)
  );

endmodule

`default_nettype wire

/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // address map
  localparam logic [ADDR_WIDTH-1:0] MEM_BASE    = 32'h8000_0000;
  localparam logic [ADDR_WIDTH-1:0] SERIAL_ADDR = 32'ha000_03f8;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } lsu_op_e;

  // same encoding as AXI size
  typedef enum logic [2:0] {
    BYTE = 3'd0,
    HALF = 3'd1,
    WORD = 3'd2
  } access_size_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds and runs the testbench; exit status is the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f verilog.f \
       --top-module npc_soc_tb -o npc_soc_sim \
  && ./obj_dir/npc_soc_sim \
  || exit 1

/* verilog.f */
hw/soc_pkg.sv
hw/lsu_axi_bridge.sv
hw/axi_addr_decoder.sv
hw/axi_mem_slave.sv
hw/axi_serial_slave.sv
hw/npc_soc.sv
dv/npc_soc_tb.sv
